// File: Bender.yml
package:
  name: scalar_unit

sources:
  - include_dirs:
      - hw
    files:
      - hw/scalar_pkg.sv
      - hw/program_sequencer.sv
      - hw/issue_queue.sv
      - hw/register_file.sv
      - hw/scalar_core.sv
      - hw/scalar_unit.sv
  - target: test
    include_dirs:
      - hw
    files:
      - testbench/tb_scalar_unit.sv

// File: hw/issue_queue.sv
`timescale 1ns/10ps
`include "scalar_params.svh"

module issue_queue #(
	parameter int DEPTH = `QUEUE_DEPTH
) (
	input	logic					clock,
	input	logic					reset,
	input	logic					push,
	input	scalar_pkg::instr_u		push_instr,
	input	logic					pop,
	output	scalar_pkg::instr_u		head,
	output	logic					full,
	output	logic					empty
);

	localparam int					PTR_W = $clog2(DEPTH);
	localparam logic [PTR_W:0]		FULL_COUNT = (PTR_W + 1)'(DEPTH);

	scalar_pkg::instr_u				mem [DEPTH];

	logic [PTR_W-1:0]				wr_ptr;
	logic [PTR_W-1:0]				rd_ptr;
	logic [PTR_W:0]					count;
	logic							do_push;
	logic							do_pop;

	// A pop frees the slot a full-queue push needs
	assign do_push	= push & (~full | pop);
	assign do_pop	= pop & ~empty;

	assign head		= mem[rd_ptr];
	assign full		= count == FULL_COUNT;
	assign empty	= count == '0;

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= push_instr;
		end
	end

	// Pointers wrap on their own for power-of-two depths
	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ptr	<= '0;
			rd_ptr	<= '0;
			count	<= '0;
		end else begin
			if (do_push) begin
				wr_ptr	<= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr	<= rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:		count <= count + 1'b1;
				2'b01:		count <= count - 1'b1;
				default:	count <= count;
			endcase
		end
	end

	assert property (@(posedge clock) disable iff (reset)
		pop |-> !empty);

	assert property (@(posedge clock) disable iff (reset)
		push && full |-> pop);

endmodule

// File: hw/program_sequencer.sv
`timescale 1ns/10ps
`include "scalar_params.svh"

module program_sequencer (
	input	logic					clock,
	input	logic					reset,
	input	scalar_pkg::store_req_t	store,
	input	logic					start,
	input	logic					full,
	output	logic					ack_st,
	output	logic					push,
	output	scalar_pkg::instr_u		push_instr
);

	scalar_pkg::instr_u				imem [`IMEM_DEPTH];

	logic [`ADDR_W-1:0]				store_ptr;
	logic [`ADDR_W-1:0]				pc;
	logic							fetching;
	logic							fetch_halt;

	//////////////////////////////
	// Program store
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (store.valid) begin
			imem[store_ptr] <= store.instr;
		end
	end

	// Store pointer only rewinds on reset
	always_ff @(posedge clock) begin
		if (reset) begin
			store_ptr	<= '0;
			ack_st		<= 1'b0;
		end else begin
			ack_st		<= store.valid;
			if (store.valid) begin
				store_ptr	<= store_ptr + 1'b1;
			end
		end
	end

	//////////////////////////////
	// Fetch
	//////////////////////////////

	// Asynchronous read at the program counter
	assign push_instr	= imem[pc];
	assign push			= fetching & ~full;
	assign fetch_halt	= push_instr.r.opcode == scalar_pkg::op_halt;

	always_ff @(posedge clock) begin
		if (reset) begin
			pc			<= '0;
			fetching	<= 1'b0;
		end else if (start) begin
			pc			<= '0;
			fetching	<= 1'b1;
		end else if (push) begin
			pc			<= pc + 1'b1;
			// Halt is the last word fetched
			if (fetch_halt) begin
				fetching	<= 1'b0;
			end
		end
	end

	// Program is written only while fetch is idle
	assert property (@(posedge clock) disable iff (reset)
		store.valid |-> !fetching);

	// Once halt is pushed, nothing more until a new start
	assert property (@(posedge clock) disable iff (reset)
		push && fetch_halt && !start |=> !push);

endmodule

// File: hw/register_file.sv
`timescale 1ns/10ps
`include "scalar_params.svh"

module register_file (
	input	logic					clock,
	input	logic					reset,
	input	logic					we,
	input	logic [`REG_IDX_W-1:0]	wr_idx,
	input	logic [`DATA_W-1:0]		wr_data,
	input	logic [`REG_IDX_W-1:0]	rd_idx1,
	input	logic [`REG_IDX_W-1:0]	rd_idx2,
	output	logic [`DATA_W-1:0]		rd_data1,
	output	logic [`DATA_W-1:0]		rd_data2
);

	logic [`DATA_W-1:0]				regs [`REG_NUM];

	// r0 is never written
	always_ff @(posedge clock) begin
		if (reset) begin
			regs <= '{default: '0};
		end else if (we && wr_idx != '0) begin
			regs[wr_idx] <= wr_data;
		end
	end

	// Write-through so a dependent read sees this cycle's result
	assign rd_data1 = (rd_idx1 == '0)			? '0 :
					  (we && rd_idx1 == wr_idx)	? wr_data :
												  regs[rd_idx1];

	assign rd_data2 = (rd_idx2 == '0)			? '0 :
					  (we && rd_idx2 == wr_idx)	? wr_data :
												  regs[rd_idx2];

endmodule

// File: hw/scalar_core.sv
`timescale 1ns/10ps
`include "scalar_params.svh"

module scalar_core (
	input	logic						clock,
	input	logic						reset,
	input	logic						en,
	input	scalar_pkg::instr_u			head,
	input	logic						empty,
	output	logic						pop,
	output	scalar_pkg::scalar_out_t	scalar_out,
	output	logic						term
);

	scalar_pkg::wb_t					wb_d;
	scalar_pkg::wb_t					wb_q;

	logic [`DATA_W-1:0]					src1_data;
	logic [`DATA_W-1:0]					src2_data;
	logic [`DATA_W-1:0]					imm_ext;
	logic [`DATA_W-1:0]					alu_result;
	logic								wb_we;

	assign pop = en & ~empty;

	//////////////////////////////
	// Operand read
	//////////////////////////////

	register_file u_regs (
		.clock		(clock),
		.reset		(reset),
		.we			(wb_we),
		.wr_idx		(wb_q.dst),
		.wr_data	(wb_q.data),
		.rd_idx1	(head.r.src1),
		.rd_idx2	(head.r.src2),
		.rd_data1	(src1_data),
		.rd_data2	(src2_data)
	);

	// Immediate view of the same word
	assign imm_ext = {{(`DATA_W - `IMM_W){head.i.imm[`IMM_W-1]}}, head.i.imm};

	//////////////////////////////
	// ALU
	//////////////////////////////

	always_comb begin
		case (head.r.opcode)
			scalar_pkg::op_add:		alu_result = src1_data + src2_data;
			scalar_pkg::op_sub:		alu_result = src1_data - src2_data;
			scalar_pkg::op_and:		alu_result = src1_data & src2_data;
			scalar_pkg::op_or:		alu_result = src1_data | src2_data;
			scalar_pkg::op_xor:		alu_result = src1_data ^ src2_data;
			scalar_pkg::op_shl:		alu_result = src1_data << src2_data[3:0];
			scalar_pkg::op_addi:	alu_result = src1_data + imm_ext;
			scalar_pkg::op_out:		alu_result = src1_data;
			default:				alu_result = '0;
		endcase
	end

	assign wb_d.valid	= pop;
	assign wb_d.op		= head.r.opcode;
	assign wb_d.dst		= head.r.dst;
	assign wb_d.data	= alu_result;

	// Bubble when nothing was popped
	always_ff @(posedge clock) begin
		if (reset) begin
			wb_q <= '0;
		end else if (pop) begin
			wb_q <= wb_d;
		end else begin
			wb_q <= '0;
		end
	end

	//////////////////////////////
	// Write-back
	//////////////////////////////

	// Only ALU ops carry a destination
	assign wb_we = wb_q.valid & (wb_q.op inside {scalar_pkg::op_add, scalar_pkg::op_sub,
		scalar_pkg::op_and, scalar_pkg::op_or, scalar_pkg::op_xor,
		scalar_pkg::op_shl, scalar_pkg::op_addi});

	assign scalar_out.valid	= wb_q.valid & (wb_q.op == scalar_pkg::op_out);
	assign scalar_out.data	= wb_q.data;
	assign term				= wb_q.valid & (wb_q.op == scalar_pkg::op_halt);

	// A popped word must be a stored instruction
	assert property (@(posedge clock) disable iff (reset)
		pop |-> !$isunknown(head));

	// Halt reaches write-back exactly one cycle after its pop
	assert property (@(posedge clock) disable iff (reset)
		pop && head.r.opcode == scalar_pkg::op_halt |=> term);

endmodule

// File: hw/scalar_params.svh
`ifndef SCALAR_PARAMS_SVH
`define SCALAR_PARAMS_SVH

//////////////////////////////
// Datapath
//////////////////////////////

// Scalar data width
`define DATA_W			16

// Register file size and index width
`define REG_NUM			16
`define REG_IDX_W		4

//////////////////////////////
// Program store and fetch
//////////////////////////////

`define IMEM_DEPTH		64
`define ADDR_W			6

// Entries between fetch and execute
`define QUEUE_DEPTH		4

//////////////////////////////
// Instruction word
//////////////////////////////

`define OPCODE_W		4
`define IMM_W			12
`define INSTR_W			24

`endif

// File: hw/scalar_pkg.sv
`include "scalar_params.svh"

package scalar_pkg;

	// Pad bits left over in the register form
	localparam int PAD_W = `INSTR_W - `OPCODE_W - 3 * `REG_IDX_W;

	//////////////////////////////
	// Instruction encoding
	//////////////////////////////

	// Codes not listed here execute as nop
	typedef enum logic [`OPCODE_W-1:0] {
		op_nop	= 0,
		op_add	= 1,
		op_sub	= 2,
		op_and	= 3,
		op_or	= 4,
		op_xor	= 5,
		op_shl	= 6,
		op_addi	= 7,
		op_out	= 8,
		op_halt	= 9
	} opcode_e;

	typedef struct packed {
		opcode_e					opcode;
		logic [`REG_IDX_W-1:0]		dst;
		logic [`REG_IDX_W-1:0]		src1;
		logic [`REG_IDX_W-1:0]		src2;
		logic [PAD_W-1:0]			pad;
	} instr_reg_t;

	typedef struct packed {
		opcode_e					opcode;
		logic [`REG_IDX_W-1:0]		dst;
		logic [`REG_IDX_W-1:0]		src1;
		logic [`IMM_W-1:0]			imm;
	} instr_imm_t;

	// Same word, decoded by opcode
	typedef union packed {
		instr_reg_t					r;
		instr_imm_t					i;
	} instr_u;

	//////////////////////////////
	// Ports and stage tokens
	//////////////////////////////

	typedef struct packed {
		logic						valid;
		instr_u						instr;
	} store_req_t;

	typedef struct packed {
		logic						valid;
		opcode_e					op;
		logic [`REG_IDX_W-1:0]		dst;
		logic [`DATA_W-1:0]			data;
	} wb_t;

	typedef struct packed {
		logic						valid;
		logic [`DATA_W-1:0]			data;
	} scalar_out_t;

endpackage

// File: hw/scalar_unit.sv
`timescale 1ns/10ps
`include "scalar_params.svh"

module scalar_unit (
	input	logic						clock,
	input	logic						reset,
	input	scalar_pkg::store_req_t		store,
	output	logic						ack_st,
	input	logic						start,
	input	logic						en,
	output	scalar_pkg::scalar_out_t	scalar_out,
	output	logic						term
);

	logic								push;
	scalar_pkg::instr_u					push_instr;
	logic								full;
	scalar_pkg::instr_u					head;
	logic								empty;
	logic								pop;

	// Fetch side
	program_sequencer u_seq (
		.clock		(clock),
		.reset		(reset),
		.store		(store),
		.start		(start),
		.full		(full),
		.ack_st		(ack_st),
		.push		(push),
		.push_instr	(push_instr)
	);

	issue_queue #(
		.DEPTH		(`QUEUE_DEPTH)
	) u_queue (
		.clock		(clock),
		.reset		(reset),
		.push		(push),
		.push_instr	(push_instr),
		.pop		(pop),
		.head		(head),
		.full		(full),
		.empty		(empty)
	);

	// Execute side
	scalar_core u_core (
		.clock		(clock),
		.reset		(reset),
		.en			(en),
		.head		(head),
		.empty		(empty),
		.pop		(pop),
		.scalar_out	(scalar_out),
		.term		(term)
	);

endmodule

// File: sim.f
+incdir+hw
hw/scalar_pkg.sv
hw/program_sequencer.sv
hw/issue_queue.sv
hw/register_file.sv
hw/scalar_core.sv
hw/scalar_unit.sv
testbench/tb_scalar_unit.sv

// File: testbench/tb_scalar_unit.sv
`timescale 1ns/10ps
`include "scalar_params.svh"

module tb_scalar_unit;

	localparam int RUN_TIMEOUT = 400;

	logic						clock;
	logic						reset;
	scalar_pkg::store_req_t		store;
	logic						ack_st;
	logic						start;
	logic						en;
	scalar_pkg::scalar_out_t	scalar_out;
	logic						term;

	logic [`INSTR_W-1:0]		prog [$];
	logic [`DATA_W-1:0]			expected [$];
	logic [`DATA_W-1:0]			got [$];
	int							errors;
	int							tests_run;
	int							tests_failed;

	scalar_unit dut_i (
		.clock		(clock),
		.reset		(reset),
		.store		(store),
		.ack_st		(ack_st),
		.start		(start),
		.en			(en),
		.scalar_out	(scalar_out),
		.term		(term)
	);

	always #10 clock = ~clock;

	task automatic next_cycle();
		@(posedge clock);
		#2;
	endtask

	task automatic reset_dut();
		reset = 1'b1;
		store = '0;
		start = 1'b0;
		en = 1'b0;
		repeat (8) next_cycle();
		reset = 1'b0;
		if (ack_st !== 1'b0 || term !== 1'b0 || scalar_out.valid !== 1'b0) begin
			$display("At %0t outputs were not idle after reset", $time);
			errors++;
		end
	endtask

	//////////////////////////////
	// Program building
	//////////////////////////////

	task automatic emit_reg(input scalar_pkg::opcode_e op, input logic [3:0] rd,
		input logic [3:0] ra, input logic [3:0] rb);
		prog.push_back({op, rd, ra, rb, 8'h00});
	endtask

	task automatic emit_imm(input scalar_pkg::opcode_e op, input logic [3:0] rd,
		input logic [3:0] ra, input logic [11:0] imm);
		prog.push_back({op, rd, ra, imm});
	endtask

	task automatic build_alu_program();
		prog.delete();
		emit_imm(scalar_pkg::op_addi, 1, 0, 12'h123);
		emit_reg(scalar_pkg::op_out, 0, 1, 0);
		// Negative immediates
		emit_imm(scalar_pkg::op_addi, 2, 0, 12'hffb);
		emit_reg(scalar_pkg::op_out, 0, 2, 0);
		emit_imm(scalar_pkg::op_addi, 3, 0, 12'h007);
		emit_reg(scalar_pkg::op_add, 4, 1, 2);
		emit_reg(scalar_pkg::op_out, 0, 4, 0);
		emit_reg(scalar_pkg::op_sub, 5, 1, 3);
		emit_reg(scalar_pkg::op_out, 0, 5, 0);
		emit_reg(scalar_pkg::op_and, 6, 1, 2);
		emit_reg(scalar_pkg::op_out, 0, 6, 0);
		emit_reg(scalar_pkg::op_or, 7, 1, 3);
		emit_reg(scalar_pkg::op_out, 0, 7, 0);
		emit_reg(scalar_pkg::op_xor, 8, 2, 3);
		emit_reg(scalar_pkg::op_out, 0, 8, 0);
		emit_reg(scalar_pkg::op_shl, 9, 1, 3);
		emit_reg(scalar_pkg::op_out, 0, 9, 0);
		emit_imm(scalar_pkg::op_addi, 10, 0, 12'h800);
		emit_reg(scalar_pkg::op_out, 0, 10, 0);
		emit_reg(scalar_pkg::op_halt, 0, 0, 0);
	endtask

	task automatic build_chain_program();
		prog.delete();
		emit_imm(scalar_pkg::op_addi, 1, 0, 12'h001);
		emit_imm(scalar_pkg::op_addi, 2, 1, 12'h002);
		emit_reg(scalar_pkg::op_add, 3, 2, 1);
		emit_reg(scalar_pkg::op_add, 4, 3, 3);
		emit_imm(scalar_pkg::op_addi, 4, 4, 12'hfff);
		emit_reg(scalar_pkg::op_out, 0, 4, 0);
		emit_reg(scalar_pkg::op_add, 5, 4, 3);
		emit_reg(scalar_pkg::op_out, 0, 5, 0);
		// r0 must stay zero
		emit_imm(scalar_pkg::op_addi, 0, 1, 12'h005);
		emit_reg(scalar_pkg::op_out, 0, 0, 0);
		emit_reg(scalar_pkg::op_add, 6, 0, 5);
		emit_reg(scalar_pkg::op_out, 0, 6, 0);
		emit_reg(scalar_pkg::op_halt, 0, 0, 0);
	endtask

	task automatic build_halt_program();
		prog.delete();
		emit_imm(scalar_pkg::op_addi, 1, 0, 12'h009);
		emit_reg(scalar_pkg::op_out, 0, 1, 0);
		emit_reg(scalar_pkg::op_halt, 0, 0, 0);
		emit_reg(scalar_pkg::op_out, 0, 1, 0);
		emit_reg(scalar_pkg::op_out, 0, 1, 0);
	endtask

	//////////////////////////////
	// Reference model
	//////////////////////////////

	function automatic void model_program();
		logic [`DATA_W-1:0]		regs [16];
		logic [`INSTR_W-1:0]	word;
		logic [3:0]				op;
		logic [`DATA_W-1:0]		a;
		logic [`DATA_W-1:0]		b;
		logic [`DATA_W-1:0]		imm;
		logic [`DATA_W-1:0]		res;
		bit						writes;
		bit						done;
		int						pc;
		int						k;
		expected.delete();
		for (k = 0; k < 16; k++) begin
			regs[k] = '0;
		end
		done = 0;
		pc = 0;
		while (!done && pc < prog.size()) begin
			word = prog[pc];
			op = word[23:20];
			a = regs[word[15:12]];
			b = regs[word[11:8]];
			imm = {{(`DATA_W - `IMM_W){word[11]}}, word[11:0]};
			writes = 1;
			res = '0;
			case (op)
				scalar_pkg::op_add:		res = a + b;
				scalar_pkg::op_sub:		res = a - b;
				scalar_pkg::op_and:		res = a & b;
				scalar_pkg::op_or:		res = a | b;
				scalar_pkg::op_xor:		res = a ^ b;
				scalar_pkg::op_shl:		res = a << b[3:0];
				scalar_pkg::op_addi:	res = a + imm;
				default:				writes = 0;
			endcase
			if (op == scalar_pkg::op_out) begin
				expected.push_back(a);
			end
			if (op == scalar_pkg::op_halt) begin
				done = 1;
			end
			if (writes && word[19:16] != 4'd0) begin
				regs[word[19:16]] = res;
			end
			pc++;
		end
	endfunction

	//////////////////////////////
	// Drivers and checks
	//////////////////////////////

	// Optional idle cycles between stores
	task automatic load_program(input bit gaps);
		int i;
		bit v;
		i = 0;
		while (i < prog.size()) begin
			v = !(gaps && ($urandom % 3 == 0));
			store.valid = v;
			store.instr = v ? prog[i] : '0;
			next_cycle();
			if (ack_st !== v) begin
				$display("FAIL %0t ns ack_st expected %b actual %b", $time, v, ack_st);
				errors++;
			end
			if (v) begin
				i++;
			end
		end
		store = '0;
		next_cycle();
		if (ack_st !== 1'b0) begin
			$display("FAIL %0t ns ack_st expected 0 actual %b", $time, ack_st);
			errors++;
		end
	endtask

	task automatic run_program(input bit rand_en);
		int cycles;
		int terms;
		int tail;
		int k;
		got.delete();
		terms = 0;
		cycles = 0;
		tail = 0;
		en = 1'b1;
		start = 1'b1;
		next_cycle();
		start = 1'b0;
		// A few quiet cycles after term catch late strobes
		while (tail < 6 && cycles < RUN_TIMEOUT) begin
			if (scalar_out.valid) begin
				got.push_back(scalar_out.data);
			end
			if (term) begin
				terms++;
			end
			if (term && scalar_out.valid) begin
				$display("At %0t term and an output strobe came together", $time);
				errors++;
			end
			if (terms > 0) begin
				tail++;
			end
			en = rand_en ? 1'($urandom % 2) : 1'b1;
			cycles++;
			next_cycle();
		end
		en = 1'b1;
		if (terms == 0) begin
			$display("Timeout: no term within %0d cycles", RUN_TIMEOUT);
			errors++;
		end else if (terms != 1) begin
			$display("term pulsed %0d times instead of once", terms);
			errors++;
		end
		if (got.size() != expected.size()) begin
			$display("Saw %0d output strobes, expected %0d", got.size(), expected.size());
			errors++;
		end
		for (k = 0; k < got.size() && k < expected.size(); k++) begin
			if (got[k] !== expected[k]) begin
				$display("FAIL %0t ns scalar_out.data[%0d] expected %h actual %h",
					$time, k, expected[k], got[k]);
				errors++;
			end
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		tests_run++;
		if (errors == errs_before) begin
			$display("%s: ok", name);
		end else begin
			tests_failed++;
			$display("%s: %0d errors", name, errors - errs_before);
		end
	endtask

	//////////////////////////////
	// Directed tests
	//////////////////////////////

	task automatic test_store_ack();
		int errs;
		errs = errors;
		reset_dut();
		build_alu_program();
		load_program(1);
		repeat (3) begin
			next_cycle();
			if (ack_st !== 1'b0) begin
				$display("At %0t ack_st rose with no store", $time);
				errors++;
			end
		end
		report_test("store_ack", errs);
	endtask

	task automatic test_program(input string name, input int kind, input bit rand_en);
		int errs;
		errs = errors;
		reset_dut();
		case (kind)
			0:			build_alu_program();
			1:			build_chain_program();
			default:	build_halt_program();
		endcase
		load_program(0);
		model_program();
		run_program(rand_en);
		// Halt test runs the same program a second time
		if (kind == 2) begin
			run_program(rand_en);
		end
		report_test(name, errs);
	endtask

	initial begin
		void'($urandom(71));
		clock = 1'b0;
		reset = 1'b1;
		store = '0;
		start = 1'b0;
		en = 1'b0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		test_store_ack();
		test_program("alu_immediate", 0, 0);
		test_program("dependency_chain", 1, 0);
		test_program("enable_backpressure", 0, 1);
		test_program("halt_restart", 2, 0);
		$display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule
